// File: aes256_enc_top.f
+incdir+tb
common/aes_pkg.sv
rtl/aes_round_key_regs.sv
aes_core/aes_sbox.sv
aes_core/aes_mix_columns.sv
aes_core/aes_enc_ctrl.sv
aes_core/aes_state_path.sv
rtl/aes256_enc_top.sv
tb/aes256_enc_tb.sv

// File: aes_core/aes_enc_ctrl.sv
/*
 Round sequencer for the byte-serial AES encryption core
 Steps KEY0, then per round 16 SUB cycles, one DRAIN and one FINISH,
 and raises done for one cycle after round NUM_ROUNDS.
 Drives the state path strobes and the round index for the key registers.
*/
`timescale 1ns/1ps

module aes_enc_ctrl import aes_pkg::*;
#(
    parameter int NUM_ROUNDS = 14
)
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,       // One-cycle strobe, ignored while busy
    output logic       busy,
    output logic       done,
    output logic       load,        // Initial key addition
    output logic       sub_step,    // Byte goes to S-box
    output logic [3:0] byte_idx,
    output logic       sbox_valid,  // S-box output ready
    output logic       finish,      // Round finish
    output logic       last_round,  // No MixColumns
    output round_idx_t round
);

    aes_state_e state_q, state_d;
    logic [3:0] byte_cnt_q;
    round_idx_t round_q;
    logic       sbox_valid_q;

    // Next state
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (start)
                begin
                    state_d = KEY0;
                end
            end
            KEY0:   state_d = SUB;
            SUB:
            begin
                if (byte_cnt_q == 4'd15)
                begin
                    state_d = DRAIN;  // All 16 bytes issued
                end
            end
            DRAIN:  state_d = FINISH;
            FINISH:
            begin
                if (round_q == round_idx_t'(NUM_ROUNDS))
                begin
                    state_d = DONE;
                end
                else
                begin
                    state_d = SUB;
                end
            end
            DONE:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q      <= IDLE;
            byte_cnt_q   <= '0;
            round_q      <= '0;
            sbox_valid_q <= 1'b0;
        end
        else
        begin
            state_q      <= state_d;
            sbox_valid_q <= (state_q == SUB);  // Matches S-box latency

            if (state_q == SUB)
            begin
                byte_cnt_q <= byte_cnt_q + 4'd1;  // Wraps to 0 after byte 15
            end
            else
            begin
                byte_cnt_q <= '0;
            end

            // Round 0 on start, bump after KEY0 and after each non-final FINISH
            if (state_q == IDLE)
            begin
                round_q <= '0;
            end
            else if ((state_q == KEY0) || ((state_q == FINISH) && (state_d == SUB)))
            begin
                round_q <= round_q + round_idx_t'(1);
            end
        end
    end

    // Strobes decoded from registered state
    assign busy       = (state_q != IDLE);
    assign done       = (state_q == DONE);
    assign load       = (state_q == KEY0);
    assign sub_step   = (state_q == SUB);
    assign byte_idx   = byte_cnt_q;
    assign sbox_valid = sbox_valid_q;
    assign finish     = (state_q == FINISH);
    assign last_round = (round_q == round_idx_t'(NUM_ROUNDS));
    assign round      = round_q;

endmodule

// File: aes_core/aes_mix_columns.sv
/*
 MixColumns over a whole AES block, purely combinational
 Each column is multiplied by the fixed matrix {02 03 01 01} rotated.
 The caller picks whether the result is used.
*/
`timescale 1ns/1ps

module aes_mix_columns import aes_pkg::*;
(
    input  block_t in_block,
    output block_t out_block
);

    always_comb
    begin
        byte_t a0, a1, a2, a3;
        out_block = '0;
        for (int c = 0; c < 4; c++)
        begin
            // Rows 0..3 of column c, byte 0 at the top bits
            a0 = in_block[127 - 32*c -: 8];
            a1 = in_block[119 - 32*c -: 8];
            a2 = in_block[111 - 32*c -: 8];
            a3 = in_block[103 - 32*c -: 8];

            // 3*x written as xtime(x) ^ x
            out_block[127 - 32*c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            out_block[119 - 32*c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            out_block[111 - 32*c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            out_block[103 - 32*c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
    end

endmodule

// File: aes_core/aes_sbox.sv
/*
 Forward AES S-box, registered
 One byte looked up per cycle, result appears one cycle after addr.
 Used as the SubBytes step of every round.
*/
`timescale 1ns/1ps

module aes_sbox import aes_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  byte_t addr,
    output byte_t data
);

    // FIPS-197 forward table, row-major by input byte
    localparam byte_t SBOX_TBL [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Output register, reads every cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data <= '0;
        end
        else
        begin
            data <= SBOX_TBL[addr];
        end
    end

endmodule

// File: aes_core/aes_state_path.sv
/*
 AES state datapath, byte-serial
 Loads plaintext with key 0, streams bytes through the S-box and
 drops each result at its ShiftRows position in a work block.
 On finish, applies MixColumns (skipped in the last round) and the round key.
 The last round's result is kept as the ciphertext until the next block ends.
*/
`timescale 1ns/1ps

module aes_state_path import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  block_t     plaintext,
    input  block_t     round_key,
    input  logic       load,        // State <= plaintext ^ key 0
    input  logic       sub_step,    // Issue byte_idx to S-box
    input  logic [3:0] byte_idx,
    input  logic       sbox_valid,  // S-box result for idx_q
    input  logic       finish,      // Close the round
    input  logic       last_round,
    output block_t     ciphertext
);

    block_t     state_q;     // Round state
    block_t     ct_q;        // Final round result
    block_t     work_q;      // Substituted and shifted bytes
    block_t     mixed;
    block_t     round_out;   // State at the end of this round
    logic [3:0] idx_q;       // byte_idx aligned to S-box output
    byte_t      sbox_in;
    byte_t      sbox_out;

    // Byte i of a block sits at bits 127-8i down
    function automatic byte_t get_byte(input block_t b, input logic [3:0] i);
        return b[8*(15 - i) +: 8];
    endfunction

    // ShiftRows target, row r col c goes to col (c - r) mod 4
    function automatic logic [3:0] shift_dest(input logic [3:0] i);
        logic [1:0] col;
        col = i[3:2] - i[1:0];  // 2-bit wrap gives the mod 4
        return {col, i[1:0]};
    endfunction

    assign sbox_in = sub_step ? get_byte(state_q, byte_idx) : '0;

    aes_sbox u_sbox (
        .clk    (clk),
        .resetn (resetn),
        .addr   (sbox_in),
        .data   (sbox_out)
    );

    aes_mix_columns u_mix (
        .in_block  (work_q),
        .out_block (mixed)
    );

    // Work block and S-box index pipe
    always_ff @(posedge clk)
    begin
        if (sub_step)
        begin
            idx_q <= byte_idx;
        end
        if (sbox_valid)
        begin
            work_q[8*(15 - shift_dest(idx_q)) +: 8] <= sbox_out;
        end
    end

    // MixColumns skipped in the last round
    assign round_out = (last_round ? work_q : mixed) ^ round_key;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q <= '0;
            ct_q    <= '0;
        end
        else if (load)
        begin
            state_q <= plaintext ^ round_key;  // AddRoundKey with key 0
        end
        else if (finish)
        begin
            state_q <= round_out;
            if (last_round)
            begin
                ct_q <= round_out;  // Visible in the done cycle
            end
        end
    end

    assign ciphertext = ct_q;  // Holds until the next done

endmodule

// File: common/aes_pkg.sv
/*
 AES core shared definitions
 Byte, block and round index types, the sequencer state encoding
 and the GF(2^8) doubling used by MixColumns and the testbench model.
 Modules pull this in with a wildcard import in their header.
*/
package aes_pkg;

    // One state byte
    typedef logic [7:0] byte_t;

    // 128-bit block, byte 0 in bits 127:120, column-major order
    typedef logic [127:0] block_t;

    // Round index, 0 to 14
    typedef logic [3:0] round_idx_t;

    // Round sequencer states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,  // Waiting for start
        KEY0   = 3'd1,  // Initial AddRoundKey
        SUB    = 3'd2,  // 16 byte steps through the S-box
        DRAIN  = 3'd3,  // Last S-box output lands
        FINISH = 3'd4,  // MixColumns and AddRoundKey
        DONE   = 3'd5   // One-cycle completion
    } aes_state_e;

    // Multiply by 2 in GF(2^8), polynomial 0x11b
    function automatic byte_t xtime(input byte_t b);
        byte_t r;
        r = {b[6:0], 1'b0};
        if (b[7])
        begin
            r = r ^ 8'h1b;  // Reduce when the top bit falls out
        end
        return r;
    endfunction

endpackage

// File: rtl/aes256_enc_top.sv
/*
 AES-256 byte-serial encryption core, top level
 Ties the round key registers, round sequencer and state path together.
 Keys are written per round before start, done pulses with the ciphertext.
*/
`timescale 1ns/1ps

module aes256_enc_top import aes_pkg::*;
#(
    parameter int NUM_ROUNDS = 14  // 10 or 12 for AES-128 or AES-192
)
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  block_t     plaintext,
    input  logic       key_wr,
    input  round_idx_t key_idx,
    input  block_t     key_data,
    output logic       busy,
    output logic       done,
    output block_t     ciphertext
);

    round_idx_t round;
    block_t     round_key;
    logic       load;
    logic       sub_step;
    logic [3:0] byte_idx;
    logic       sbox_valid;
    logic       finish;
    logic       last_round;

    aes_round_key_regs #(.NUM_ROUNDS(NUM_ROUNDS)) u_key_regs (
        .clk       (clk),
        .resetn    (resetn),
        .key_wr    (key_wr),
        .key_idx   (key_idx),
        .key_data  (key_data),
        .round     (round),
        .round_key (round_key)
    );

    aes_enc_ctrl #(.NUM_ROUNDS(NUM_ROUNDS)) u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .load       (load),
        .sub_step   (sub_step),
        .byte_idx   (byte_idx),
        .sbox_valid (sbox_valid),
        .finish     (finish),
        .last_round (last_round),
        .round      (round)
    );

    aes_state_path u_state_path (
        .clk        (clk),
        .resetn     (resetn),
        .plaintext  (plaintext),
        .round_key  (round_key),
        .load       (load),
        .sub_step   (sub_step),
        .byte_idx   (byte_idx),
        .sbox_valid (sbox_valid),
        .finish     (finish),
        .last_round (last_round),
        .ciphertext (ciphertext)
    );

endmodule

// File: rtl/aes_round_key_regs.sv
/*
 Round key storage beside the AES datapath
 Holds NUM_ROUNDS+1 expanded keys, loaded one per key_wr strobe.
 The sequencer's round index picks the key combinationally.
*/
`timescale 1ns/1ps

module aes_round_key_regs import aes_pkg::*;
#(
    parameter int NUM_ROUNDS = 14
)
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       key_wr,     // Write strobe
    input  round_idx_t key_idx,    // Slot to write
    input  block_t     key_data,
    input  round_idx_t round,      // Current round from sequencer
    output block_t     round_key
);

    block_t keys [0:NUM_ROUNDS];   // One slot per round plus key 0

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i <= NUM_ROUNDS; i++)
            begin
                keys[i] <= '0;
            end
        end
        else if (key_wr && (key_idx <= round_idx_t'(NUM_ROUNDS)))
        begin
            keys[key_idx] <= key_data;  // Out-of-range slots dropped
        end
    end

    // Combinational read, no added latency
    assign round_key = keys[round];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the AES-256 core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f aes256_enc_top.f \
    --top-module aes256_enc_tb -o aes_sim
./obj_dir/aes_sim > sim.log 2>&1
cat sim.log
if grep -qF '*** FAILED ***' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: tb/aes_ref_model.svh
/*
 Reference model for the AES-256 encryption testbench
 Builds the S-box from the GF(2^8) inverse and the affine map, expands a
 256-bit key into 15 round keys and encrypts one block with them.
 Included inside the testbench module body.
*/
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

logic [7:0]   ref_sbox [0:255];  // Filled by build_sbox
logic [127:0] ref_rk [0:14];     // Round keys from the last expand_key

// Shift-and-add multiply, polynomial 0x11b
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
        begin
            p = p ^ x;
        end
        x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};  // Next power of 2
    end
    return p;
endfunction

function automatic logic [7:0] rotl8(input logic [7:0] v, input int n);
    return (v << n) | (v >> (8 - n));
endfunction

// Inverse by search, then the affine transform
task automatic build_sbox();
    logic [7:0] inv;
    for (int x = 0; x < 256; x++)
    begin
        inv = 8'h00;  // 0 has no inverse, maps to 0
        for (int y = 1; y < 256; y++)
        begin
            if (gf_mul(8'(x), 8'(y)) == 8'h01)
            begin
                inv = 8'(y);
            end
        end
        ref_sbox[x] = inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3)
                      ^ rotl8(inv, 4) ^ 8'h63;
    end
endtask

function automatic logic [31:0] sub_word(input logic [31:0] w);
    return {ref_sbox[w[31:24]], ref_sbox[w[23:16]], ref_sbox[w[15:8]], ref_sbox[w[7:0]]};
endfunction

// AES-256 schedule, Nk = 8, 60 words
task automatic expand_key(input logic [255:0] key);
    logic [31:0] w [0:59];
    logic [31:0] t;
    logic [7:0]  rcon;
    rcon = 8'h01;
    for (int i = 0; i < 8; i++)
    begin
        w[i] = key[255 - 32*i -: 32];
    end
    for (int i = 8; i < 60; i++)
    begin
        t = w[i - 1];
        if (i % 8 == 0)
        begin
            t    = sub_word({t[23:0], t[31:24]}) ^ {rcon, 24'h0};  // RotWord first
            rcon = gf_mul(rcon, 8'h02);
        end
        else if (i % 8 == 4)
        begin
            t = sub_word(t);  // Extra SubWord for 256-bit keys
        end
        w[i] = w[i - 8] ^ t;
    end
    for (int r = 0; r < 15; r++)
    begin
        ref_rk[r] = {w[4*r], w[4*r + 1], w[4*r + 2], w[4*r + 3]};
    end
endtask

// Encrypt with the keys in ref_rk, byte 4c+r is row r of column c
function automatic logic [127:0] ref_encrypt(input logic [127:0] pt);
    logic [7:0]   s [0:15];
    logic [7:0]   t [0:15];
    logic [127:0] out;
    for (int i = 0; i < 16; i++)
    begin
        s[i] = pt[127 - 8*i -: 8] ^ ref_rk[0][127 - 8*i -: 8];
    end
    for (int rnd = 1; rnd <= 14; rnd++)
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                t[4*c + r] = ref_sbox[s[4*((c + r) % 4) + r]];  // Row r rotated left by r
            end
        end
        if (rnd == 14)
        begin
            s = t;  // Last round has no MixColumns
        end
        else
        begin
            for (int c = 0; c < 4; c++)
            begin
                s[4*c]     = gf_mul(t[4*c], 2) ^ gf_mul(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
                s[4*c + 1] = t[4*c] ^ gf_mul(t[4*c+1], 2) ^ gf_mul(t[4*c+2], 3) ^ t[4*c+3];
                s[4*c + 2] = t[4*c] ^ t[4*c+1] ^ gf_mul(t[4*c+2], 2) ^ gf_mul(t[4*c+3], 3);
                s[4*c + 3] = gf_mul(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gf_mul(t[4*c+3], 2);
            end
        end
        for (int i = 0; i < 16; i++)
        begin
            s[i] = s[i] ^ ref_rk[rnd][127 - 8*i -: 8];
        end
    end
    for (int i = 0; i < 16; i++)
    begin
        out[127 - 8*i -: 8] = s[i];
    end
    return out;
endfunction

`endif

// File: tb/aes256_enc_tb.sv
/*
 Testbench for the byte-serial AES-256 encryption core
 Writes expanded keys, starts blocks and compares each ciphertext
 with the included reference model. A negedge monitor tracks busy,
 done pulses and ciphertext hold. Random data from a Galois LFSR.
*/
`timescale 1ns/1ps

module aes256_enc_tb import aes_pkg::*;
();

    localparam int NUM_ROUNDS   = 14;
    localparam int NUM_BLOCKS   = 30;
    localparam int BLOCK_CYCLES = 300;  // Per block budget
    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = 1 + NUM_ROUNDS * 18;  // Start edge to done
    localparam logic [255:0] KAT_KEY =
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
    localparam block_t KAT_PT = 128'h00112233445566778899aabbccddeeff;
    localparam block_t KAT_CT = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic       clk;
    logic       resetn;
    logic       start;
    logic       key_wr;
    round_idx_t key_idx;
    block_t     plaintext;
    block_t     key_data;
    logic       busy;
    logic       done;
    block_t     ciphertext;

    int          errors;
    int          checks;
    logic [31:0] lfsr_q;

    // Monitor state, owned by the negedge process
    int     mon_errors   = 0;
    int     done_count   = 0;
    int     accepted     = 0;
    logic   exp_busy     = 1'b0;
    logic   done_prev    = 1'b0;
    block_t last_done_ct = '0;  // Ciphertext is zero out of reset

    `include "aes_ref_model.svh"

    aes256_enc_top #(.NUM_ROUNDS(NUM_ROUNDS)) u_dut (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .plaintext  (plaintext),
        .key_wr     (key_wr),
        .key_idx    (key_idx),
        .key_data   (key_data),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;  // 4 ns period
        end
    end

    initial
    begin
        repeat (RESET_CYCLES + NUM_BLOCKS * BLOCK_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    // Galois step, one bit out per call
    function automatic logic rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic logic [255:0] rand_bits(input int n);
        logic [255:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[254:0], rand_bit()};
        end
        return r;
    endfunction

    task automatic check_block(input string name, input block_t got, input block_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Expand in the model, then one key_wr per round key
    task automatic load_keys(input logic [255:0] key);
        expand_key(key);
        for (int i = 0; i <= NUM_ROUNDS; i++)
        begin
            @(posedge clk);
            key_wr   <= 1'b1;
            key_idx  <= round_idx_t'(i);
            key_data <= ref_rk[i];
        end
        @(posedge clk);
        key_wr <= 1'b0;
    endtask

    task automatic pulse_start(input block_t pt);
        @(posedge clk);
        start     <= 1'b1;
        plaintext <= pt;  // Held until the next start
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Cycles counted from the negedge after the start edge
    task automatic wait_done(output block_t ct, output int cycles);
        cycles = 0;
        ct     = '0;
        @(negedge clk);
        while (!done && cycles < BLOCK_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        if (done)
        begin
            ct = ciphertext;
        end
        else
        begin
            errors++;
            $display("No done within %0d cycles after start", BLOCK_CYCLES);
        end
    endtask

    task automatic run_block(input logic [255:0] key, input block_t pt, output block_t ct);
        int cycles;
        load_keys(key);
        pulse_start(pt);
        wait_done(ct, cycles);
        checks++;
        if (cycles != LATENCY)
        begin
            errors++;
            $display("CHECK FAILED latency: got %h expected %h", cycles, LATENCY);
        end
    endtask

    // Busy, done and hold rules, sampled mid-cycle
    always @(negedge clk)
    begin
        if (resetn)
        begin
            if (busy !== exp_busy)
            begin
                mon_errors++;
                $display("CHECK FAILED busy: got %h expected %h", busy, exp_busy);
            end
            if (done && done_prev)
            begin
                mon_errors++;
                $display("done stayed high for more than one cycle");
            end
            if (done && !exp_busy)
            begin
                mon_errors++;
                $display("done appeared without an accepted start");
            end
            if (done)
            begin
                done_count++;
                last_done_ct = ciphertext;
            end
            else if (ciphertext !== last_done_ct)
            begin
                mon_errors++;
                $display("CHECK FAILED ciphertext: got %h expected %h", ciphertext,
                         last_done_ct);
            end
            if (start && !busy)
            begin
                exp_busy = 1'b1;  // Taken at the next edge
                accepted++;
            end
            else if (done)
            begin
                exp_busy = 1'b0;
            end
            done_prev = done;
        end
    end

    initial
    begin
        block_t       ct;
        block_t       pt_a;
        block_t       pt_b;
        logic [255:0] key;
        int           cycles;
        int           dones_before;
        errors    = 0;
        checks    = 0;
        lfsr_q    = 32'hbfda;
        resetn    = 1'b0;
        start     = 1'b0;
        key_wr    = 1'b0;
        key_idx   = '0;
        key_data  = '0;
        plaintext = '0;
        build_sbox();
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        // Idle outputs after reset
        @(negedge clk);
        checks++;
        if (busy !== 1'b0 || done !== 1'b0)
        begin
            errors++;
            $display("CHECK FAILED busy/done: got %h/%h expected 0/0", busy, done);
        end
        check_block("ciphertext after reset", ciphertext, '0);

        // FIPS-197 AES-256 vector
        expand_key(KAT_KEY);
        check_block("model known answer", ref_encrypt(KAT_PT), KAT_CT);
        run_block(KAT_KEY, KAT_PT, ct);
        check_block("ciphertext known answer", ct, KAT_CT);

        for (int n = 0; n < 20; n++)
        begin
            key  = rand_bits(256);
            pt_a = block_t'(rand_bits(128));
            run_block(key, pt_a, ct);
            check_block("ciphertext random", ct, ref_encrypt(pt_a));
        end

        // Second start mid-run must be dropped
        key  = rand_bits(256);
        pt_a = block_t'(rand_bits(128));
        pt_b = ~pt_a;
        load_keys(key);
        dones_before = done_count;
        pulse_start(pt_a);
        repeat (10) @(posedge clk);
        start     <= 1'b1;
        plaintext <= pt_b;
        @(posedge clk);
        start <= 1'b0;
        wait_done(ct, cycles);
        check_block("ciphertext start while busy", ct, ref_encrypt(pt_a));
        repeat (20) @(posedge clk);
        checks++;
        if (done_count - dones_before != 1)
        begin
            errors++;
            $display("CHECK FAILED done count: got %h expected %h", done_count - dones_before, 1);
        end

        // Same plaintext, keys rewritten between blocks
        pt_a = block_t'(rand_bits(128));
        for (int n = 0; n < 2; n++)
        begin
            key = rand_bits(256);
            run_block(key, pt_a, ct);
            check_block("ciphertext key update", ct, ref_encrypt(pt_a));
        end

        repeat (5) @(posedge clk);
        checks++;
        if (done_count != accepted)
        begin
            errors++;
            $display("CHECK FAILED dones vs starts: got %h expected %h", done_count, accepted);
        end
        $display("Checks: %0d, errors: %0d, monitor errors: %0d", checks, errors, mon_errors);
        if (errors == 0 && mon_errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
